/* rtl/pet_bus_pkg.sv */
package pet_bus_pkg;

    localparam int DATA_WIDTH     = 8;
    localparam int CPU_ADDR_WIDTH = 16;
    localparam int WB_ADDR_WIDTH  = 17;    // MSB picks registers (1) or RAM (0)

    // Bus timing, in sys clocks per CPU cycle
    localparam int SLOT_COUNT = 16;
    localparam int SLOT_WIDTH = $clog2(SLOT_COUNT);
    localparam logic [SLOT_WIDTH-1:0] CPU_FIRST_SLOT        = 4'd8;
    localparam logic [SLOT_WIDTH-1:0] CPU_CLOCK_SLOT        = 4'd12;
    localparam logic [SLOT_WIDTH-1:0] CTRL_LAST_ACCEPT_SLOT = 4'd4;  // Access done by slot 8

    // PET memory map, upper address bits of each region
    localparam logic [3:0]  VRAM_BASE = 4'h8;      // 8000-8FFF
    localparam logic [7:0]  IO_BASE   = 8'hE8;     // E800-E8FF
    localparam logic [11:0] PIA1_BASE = 12'hE81;
    localparam logic [11:0] PIA2_BASE = 12'hE82;
    localparam logic [11:0] VIA_BASE  = 12'hE84;

    // Read-only bounds, ROM1 ends where the IO page starts
    localparam logic [CPU_ADDR_WIDTH-1:0] ROM1_BASE = 16'h9000;
    localparam logic [CPU_ADDR_WIDTH-1:0] ROM2_BASE = 16'hF000;

    // Register offsets
    localparam logic [CPU_ADDR_WIDTH-1:0] REG_STATUS     = 16'd0;
    localparam logic [CPU_ADDR_WIDTH-1:0] REG_CPU_CTRL   = 16'd1;
    localparam logic [CPU_ADDR_WIDTH-1:0] REG_VIDEO_MASK = 16'd2;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    data;     // Controller -> peripheral
    } wb_req_t;

    typedef struct packed {
        logic                  stall;
        logic                  ack;
        logic [DATA_WIDTH-1:0] data;        // Peripheral -> controller
    } wb_rsp_t;

    // Bridge drive onto the board bus
    typedef struct packed {
        logic                      oe;
        logic                      we;
        logic [CPU_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     dout;
        logic                      doe;
    } ram_ctl_t;

    // Bit 0 ready, bit 1 reset, bit 2 nmi
    typedef struct packed {
        logic nmi;
        logic reset;
        logic ready;
    } cpu_ctrl_t;

endpackage

/* rtl/bus_timing.sv */
`timescale 1ns/1ps

module bus_timing (
    input  logic sys_clock_i,
    input  logic sys_reset_ni,

    output logic cpu_be_o,              // CPU owns the bus
    output logic cpu_clock_o,           // CPU phi2
    output logic cpu_data_strobe_o,     // Last slot of the CPU cycle
    output logic ctrl_window_o          // Bridge may accept a request
);
    logic [pet_bus_pkg::SLOT_WIDTH-1:0] slot_q;

    // Free running slot counter, one CPU cycle per wrap
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            slot_q <= '0;
        end else if (slot_q == pet_bus_pkg::SLOT_WIDTH'(pet_bus_pkg::SLOT_COUNT - 1)) begin
            slot_q <= '0;
        end else begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // Slots 0-7 belong to the controller, 8-15 to the CPU
    always_comb begin
        cpu_be_o      = (slot_q >= pet_bus_pkg::CPU_FIRST_SLOT);
        cpu_clock_o   = (slot_q >= pet_bus_pkg::CPU_CLOCK_SLOT);
        ctrl_window_o = (slot_q <= pet_bus_pkg::CTRL_LAST_ACCEPT_SLOT);
    end

    // Data is stable on the bus by the end of phi2
    assign cpu_data_strobe_o =
        (slot_q == pet_bus_pkg::SLOT_WIDTH'(pet_bus_pkg::SLOT_COUNT - 1));

endmodule

/* rtl/wb_address_map.sv */
`timescale 1ns/1ps

module wb_address_map (
    input  pet_bus_pkg::wb_req_t wb_req_i,
    output pet_bus_pkg::wb_rsp_t wb_rsp_o,

    output logic ram_sel_o,
    output logic reg_sel_o,

    input  pet_bus_pkg::wb_rsp_t ram_rsp_i,
    input  pet_bus_pkg::wb_rsp_t reg_rsp_i
);
    logic reg_space;

    assign reg_space = wb_req_i.addr[pet_bus_pkg::WB_ADDR_WIDTH-1];

    always_comb begin
        ram_sel_o = wb_req_i.cyc && !reg_space;
        reg_sel_o = wb_req_i.cyc && reg_space;

        // Stall follows the addressed target, idle bus never stalls
        if (ram_sel_o) begin
            wb_rsp_o.stall = ram_rsp_i.stall;
        end else if (reg_sel_o) begin
            wb_rsp_o.stall = reg_rsp_i.stall;
        end else begin
            wb_rsp_o.stall = 1'b0;
        end

        // Only one request in flight, so at most one ack at a time
        wb_rsp_o.ack  = ram_rsp_i.ack | reg_rsp_i.ack;
        wb_rsp_o.data = reg_rsp_i.ack ? reg_rsp_i.data : ram_rsp_i.data;
    end

endmodule

/* rtl/ram_bridge.sv */
`timescale 1ns/1ps

module ram_bridge (
    input  logic                 sys_clock_i,
    input  logic                 sys_reset_ni,

    input  pet_bus_pkg::wb_req_t wb_req_i,
    input  logic                 sel_i,
    input  logic                 ctrl_window_i,
    output pet_bus_pkg::wb_rsp_t wb_rsp_o,

    input  logic [pet_bus_pkg::DATA_WIDTH-1:0] ram_data_i,   // Shared board data bus
    output pet_bus_pkg::ram_ctl_t              ram_ctl_o
);
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        ACK
    } state_t;

    state_t state_q;
    logic   second_q;       // Second clock of OE/WE
    logic   we_q;
    logic   stall;
    logic   accept;

    logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] addr_q;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     wdata_q;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     rdata_q;

    assign stall  = !ctrl_window_i || (state_q != IDLE);
    assign accept = sel_i && wb_req_i.cyc && wb_req_i.stb && !stall;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            state_q  <= IDLE;
            second_q <= 1'b0;
            we_q     <= 1'b0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q  <= ACCESS;
                        second_q <= 1'b0;
                        we_q     <= wb_req_i.we;
                    end
                end
                ACCESS: begin
                    second_q <= 1'b1;
                    if (second_q) begin
                        state_q <= ACK;
                    end
                end
                default: state_q <= IDLE;   // ACK lasts one clock
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            addr_q  <= wb_req_i.addr[pet_bus_pkg::CPU_ADDR_WIDTH-1:0];
            wdata_q <= wb_req_i.data;
        end
        if ((state_q == ACCESS) && second_q) begin
            rdata_q <= ram_data_i;  // RAM output has settled by now
        end
    end

    always_comb begin
        ram_ctl_o.oe   = (state_q == ACCESS) && !we_q;
        ram_ctl_o.we   = (state_q == ACCESS) && we_q;
        ram_ctl_o.addr = addr_q;
        ram_ctl_o.dout = wdata_q;
        ram_ctl_o.doe  = (state_q == ACCESS) && we_q;

        wb_rsp_o.stall = stall;
        wb_rsp_o.ack   = (state_q == ACK);
        wb_rsp_o.data  = rdata_q;
    end

endmodule

/* rtl/control_regs.sv */
`timescale 1ns/1ps

module control_regs (
    input  logic                 sys_clock_i,
    input  logic                 sys_reset_ni,

    input  pet_bus_pkg::wb_req_t wb_req_i,
    input  logic                 sel_i,
    output pet_bus_pkg::wb_rsp_t wb_rsp_o,

    // Configuration straps
    input  logic config_crt_i,
    input  logic config_keyboard_i,
    input  logic graphic_i,

    output pet_bus_pkg::cpu_ctrl_t cpu_ctrl_o,
    output logic [1:0]             video_ram_mask_o    // Bit 0 A10, bit 1 A11
);
    logic                                   accept;
    logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] offset;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     read_data;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     rdata_q;
    logic                                   ack_q;
    pet_bus_pkg::cpu_ctrl_t                 cpu_ctrl_q;
    logic [1:0]                             mask_q;

    assign accept = sel_i && wb_req_i.cyc && wb_req_i.stb;     // Never stalls
    assign offset = wb_req_i.addr[pet_bus_pkg::CPU_ADDR_WIDTH-1:0];

    always_comb begin
        read_data = '0;                     // Unmapped offsets read 0
        case (offset)
            pet_bus_pkg::REG_STATUS: begin
                read_data[2:0] = {graphic_i, config_keyboard_i, config_crt_i};
            end
            pet_bus_pkg::REG_CPU_CTRL:   read_data[2:0] = cpu_ctrl_q;
            pet_bus_pkg::REG_VIDEO_MASK: read_data[1:0] = mask_q;
            default: ;
        endcase
    end

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            cpu_ctrl_q <= '{nmi: 1'b0, reset: 1'b1, ready: 1'b0};  // CPU held in reset
            mask_q     <= 2'b11;                                    // No video wrap
            ack_q      <= 1'b0;
        end else begin
            ack_q <= accept;
            if (accept && wb_req_i.we) begin
                case (offset)
                    pet_bus_pkg::REG_CPU_CTRL:   cpu_ctrl_q <= wb_req_i.data[2:0];
                    pet_bus_pkg::REG_VIDEO_MASK: mask_q     <= wb_req_i.data[1:0];
                    default: ;                  // Status is read-only
                endcase
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            rdata_q <= read_data;
        end
    end

    always_comb begin
        wb_rsp_o.stall = 1'b0;
        wb_rsp_o.ack   = ack_q;
        wb_rsp_o.data  = rdata_q;
    end

    assign cpu_ctrl_o       = cpu_ctrl_q;
    assign video_ram_mask_o = mask_q;

endmodule

/* rtl/bus_steering.sv */
`timescale 1ns/1ps

module bus_steering (
    input  logic cpu_be_i,
    input  logic cpu_clock_i,
    input  logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic cpu_we_i,

    input  logic [1:0]            video_ram_mask_i,
    input  pet_bus_pkg::ram_ctl_t ram_ctl_i,

    output logic ram_oe_o,
    output logic ram_we_o,
    output logic ram_addr_a10_o,
    output logic ram_addr_a11_o,

    output logic io_oe_o,
    output logic pia1_cs_o,
    output logic pia2_cs_o,
    output logic via_cs_o,

    output logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_o,
    output logic                                   cpu_addr_oe_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_o,
    output logic                                   cpu_data_oe_o
);
    logic is_io;
    logic is_vram;
    logic is_readonly;
    logic ram_en;
    logic pia1_en;
    logic pia2_en;
    logic via_en;
    logic cpu_rd_en;
    logic cpu_wr_en;
    logic a10_keep;
    logic a11_keep;

    // CPU address decode
    always_comb begin
        is_io   = cpu_addr_i[pet_bus_pkg::CPU_ADDR_WIDTH-1 -: 8]  == pet_bus_pkg::IO_BASE;
        is_vram = cpu_addr_i[pet_bus_pkg::CPU_ADDR_WIDTH-1 -: 4]  == pet_bus_pkg::VRAM_BASE;
        pia1_en = cpu_addr_i[pet_bus_pkg::CPU_ADDR_WIDTH-1 -: 12] == pet_bus_pkg::PIA1_BASE;
        pia2_en = cpu_addr_i[pet_bus_pkg::CPU_ADDR_WIDTH-1 -: 12] == pet_bus_pkg::PIA2_BASE;
        via_en  = cpu_addr_i[pet_bus_pkg::CPU_ADDR_WIDTH-1 -: 12] == pet_bus_pkg::VIA_BASE;

        // 9000-E7FF and F000-FFFF hold the ROM image
        is_readonly = ((cpu_addr_i >= pet_bus_pkg::ROM1_BASE)
                       && (cpu_addr_i < {pet_bus_pkg::IO_BASE, 8'h00}))
                      || (cpu_addr_i >= pet_bus_pkg::ROM2_BASE);
        ram_en = !is_io;                    // RAM backs everything but the IO page
    end

    assign cpu_rd_en = cpu_be_i && !cpu_we_i;
    assign cpu_wr_en = cpu_be_i && cpu_we_i && cpu_clock_i;    // Write only during phi2

    assign io_oe_o   = is_io   && cpu_be_i;
    assign pia1_cs_o = pia1_en && cpu_be_i;
    assign pia2_cs_o = pia2_en && cpu_be_i;
    assign via_cs_o  = via_en  && cpu_be_i;

    // Bridge strobes only exist outside the CPU phase
    assign ram_oe_o = (cpu_rd_en && ram_en) || ram_ctl_i.oe;
    assign ram_we_o = (cpu_wr_en && ram_en && !is_readonly) || ram_ctl_i.we;

    // Bridge drives address and data while the CPU is off the bus
    assign cpu_addr_oe_o = !cpu_be_i;
    assign cpu_addr_o    = ram_ctl_i.addr;
    assign cpu_data_o    = ram_ctl_i.dout;
    assign cpu_data_oe_o = ram_ctl_i.doe && !cpu_be_i;

    // Video RAM wrap, masked bits read as 0
    assign a10_keep = !is_vram || video_ram_mask_i[0];
    assign a11_keep = !is_vram || video_ram_mask_i[1];

    assign ram_addr_a10_o = cpu_be_i ? (cpu_addr_i[10] && a10_keep) : ram_ctl_i.addr[10];
    assign ram_addr_a11_o = cpu_be_i ? (cpu_addr_i[11] && a11_keep) : ram_ctl_i.addr[11];

endmodule

/* rtl/pet_bus_top.sv */
`timescale 1ns/1ps

module pet_bus_top (
    input  logic sys_clock_i,
    input  logic sys_reset_ni,

    // Bus controller (MCU side)
    input  pet_bus_pkg::wb_req_t wb_req_i,
    output pet_bus_pkg::wb_rsp_t wb_rsp_o,

    // CPU
    input  logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                                   cpu_we_i,
    output logic                                   cpu_be_o,
    output logic                                   cpu_clock_o,
    output logic                                   cpu_ready_o,
    output logic                                   cpu_reset_o,
    output logic                                   cpu_nmi_o,
    output logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_o,
    output logic                                   cpu_addr_oe_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_o,
    output logic                                   cpu_data_oe_o,

    // RAM and chip selects
    output logic ram_oe_o,
    output logic ram_we_o,
    output logic ram_addr_a10_o,
    output logic ram_addr_a11_o,
    output logic io_oe_o,
    output logic pia1_cs_o,
    output logic pia2_cs_o,
    output logic via_cs_o,

    // Straps
    input  logic config_crt_i,
    input  logic config_keyboard_i,
    input  logic graphic_i
);
    logic                  ctrl_window;
    logic                  ram_sel;
    logic                  reg_sel;
    pet_bus_pkg::wb_rsp_t  ram_rsp;
    pet_bus_pkg::wb_rsp_t  reg_rsp;
    pet_bus_pkg::ram_ctl_t ram_ctl;
    logic [1:0]            video_ram_mask;

    bus_timing u_timing (
        .sys_clock_i      (sys_clock_i),
        .sys_reset_ni     (sys_reset_ni),
        .cpu_be_o         (cpu_be_o),
        .cpu_clock_o      (cpu_clock_o),
        .cpu_data_strobe_o(),                // No CPU-side peripheral latches data here
        .ctrl_window_o    (ctrl_window)
    );

    wb_address_map u_map (
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .ram_sel_o(ram_sel),
        .reg_sel_o(reg_sel),
        .ram_rsp_i(ram_rsp),
        .reg_rsp_i(reg_rsp)
    );

    ram_bridge u_ram_bridge (
        .sys_clock_i  (sys_clock_i),
        .sys_reset_ni (sys_reset_ni),
        .wb_req_i     (wb_req_i),
        .sel_i        (ram_sel),
        .ctrl_window_i(ctrl_window),
        .wb_rsp_o     (ram_rsp),
        .ram_data_i   (cpu_data_i),          // RAM shares the CPU data bus
        .ram_ctl_o    (ram_ctl)
    );

    control_regs u_regs (
        .sys_clock_i      (sys_clock_i),
        .sys_reset_ni     (sys_reset_ni),
        .wb_req_i         (wb_req_i),
        .sel_i            (reg_sel),
        .wb_rsp_o         (reg_rsp),
        .config_crt_i     (config_crt_i),
        .config_keyboard_i(config_keyboard_i),
        .graphic_i        (graphic_i),
        .cpu_ctrl_o       ({cpu_nmi_o, cpu_reset_o, cpu_ready_o}),
        .video_ram_mask_o (video_ram_mask)
    );

    bus_steering u_steering (
        .cpu_be_i        (cpu_be_o),
        .cpu_clock_i     (cpu_clock_o),
        .cpu_addr_i      (cpu_addr_i),
        .cpu_we_i        (cpu_we_i),
        .video_ram_mask_i(video_ram_mask),
        .ram_ctl_i       (ram_ctl),
        .ram_oe_o        (ram_oe_o),
        .ram_we_o        (ram_we_o),
        .ram_addr_a10_o  (ram_addr_a10_o),
        .ram_addr_a11_o  (ram_addr_a11_o),
        .io_oe_o         (io_oe_o),
        .pia1_cs_o       (pia1_cs_o),
        .pia2_cs_o       (pia2_cs_o),
        .via_cs_o        (via_cs_o),
        .cpu_addr_o      (cpu_addr_o),
        .cpu_addr_oe_o   (cpu_addr_oe_o),
        .cpu_data_o      (cpu_data_o),
        .cpu_data_oe_o   (cpu_data_oe_o)
    );

endmodule

/* tests/pet_bus_assertions.sv */
`timescale 1ns/1ps

module pet_bus_assertions (
    input logic                  sys_clock_i,
    input logic                  cpu_be_i,
    input pet_bus_pkg::ram_ctl_t ram_ctl_i,
    input logic                  ram_oe_i,
    input logic                  ram_we_i,
    input logic                  io_oe_i
);

    // Bridge strobes belong to the controller phase only
    bridge_outside_cpu_phase: assert property (@(posedge sys_clock_i)
        !(cpu_be_i && (ram_ctl_i.oe || ram_ctl_i.we)))
        else $error("bridge RAM strobe active while the CPU owns the bus");

    io_excludes_ram: assert property (@(posedge sys_clock_i)
        !(io_oe_i && (ram_oe_i || ram_we_i)))
        else $error("IO page selected together with a RAM strobe");

    io_needs_cpu: assert property (@(posedge sys_clock_i)
        io_oe_i |-> (cpu_be_i && !ram_ctl_i.doe))   // IO is a CPU-only target
        else $error("IO output enable outside the CPU phase or during a bridge write");

endmodule

/* tests/tb_pet_bus.sv */
`timescale 1ns/1ps

module tb_pet_bus;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int CPU_SAMPLES    = 40;

    logic sys_clock;
    logic sys_reset_n;

    pet_bus_pkg::wb_req_t wb_req;
    pet_bus_pkg::wb_rsp_t wb_rsp;

    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data_in;
    logic        cpu_we;
    logic        cpu_be;
    logic        cpu_clock;
    logic        cpu_ready;
    logic        cpu_reset;
    logic        cpu_nmi;
    logic [15:0] cpu_addr_out;
    logic        cpu_addr_oe;
    logic [7:0]  cpu_data_out;
    logic        cpu_data_oe;
    logic        ram_oe;
    logic        ram_we;
    logic        ram_a10;
    logic        ram_a11;
    logic        io_oe;
    logic        pia1_cs;
    logic        pia2_cs;
    logic        via_cs;
    logic        config_crt;
    logic        config_keyboard;
    logic        graphic;

    logic [7:0]  ram_mem [0:65535];         // Board RAM behind the bus
    logic [7:0]  expected_mem [0:65535];    // What the controller wrote
    logic [3:0]  slot_model;                // Expected timing slot
    logic [31:0] lfsr_state;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    pet_bus_top u_dut (
        .sys_clock_i      (sys_clock),
        .sys_reset_ni     (sys_reset_n),
        .wb_req_i         (wb_req),
        .wb_rsp_o         (wb_rsp),
        .cpu_addr_i       (cpu_addr),
        .cpu_data_i       (cpu_data_in),
        .cpu_we_i         (cpu_we),
        .cpu_be_o         (cpu_be),
        .cpu_clock_o      (cpu_clock),
        .cpu_ready_o      (cpu_ready),
        .cpu_reset_o      (cpu_reset),
        .cpu_nmi_o        (cpu_nmi),
        .cpu_addr_o       (cpu_addr_out),
        .cpu_addr_oe_o    (cpu_addr_oe),
        .cpu_data_o       (cpu_data_out),
        .cpu_data_oe_o    (cpu_data_oe),
        .ram_oe_o         (ram_oe),
        .ram_we_o         (ram_we),
        .ram_addr_a10_o   (ram_a10),
        .ram_addr_a11_o   (ram_a11),
        .io_oe_o          (io_oe),
        .pia1_cs_o        (pia1_cs),
        .pia2_cs_o        (pia2_cs),
        .via_cs_o         (via_cs),
        .config_crt_i     (config_crt),
        .config_keyboard_i(config_keyboard),
        .graphic_i        (graphic)
    );

    bind bus_steering pet_bus_assertions u_assertions (
        .sys_clock_i(tb_pet_bus.sys_clock),
        .cpu_be_i   (cpu_be_i),
        .ram_ctl_i  (ram_ctl_i),
        .ram_oe_i   (ram_oe_o),
        .ram_we_i   (ram_we_o),
        .io_oe_i    (io_oe_o)
    );

    initial begin
        sys_clock = 1'b0;
        forever #2 sys_clock = ~sys_clock;
    end

    // RAM answers the bridge only while the controller owns the bus
    assign cpu_data_in = (ram_oe && !cpu_be) ? ram_mem[cpu_addr_out] : 8'h00;

    always @(negedge sys_clock) begin
        if (ram_we && !cpu_be) begin
            ram_mem[cpu_addr_out] = cpu_data_out;
        end
    end

    // Slot 0 after reset, one step per clock
    always @(posedge sys_clock or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            slot_model <= 4'd0;
        end else begin
            slot_model <= slot_model + 4'd1;
        end
    end

    // Ownership and bus drivers follow the slot schedule
    always @(negedge sys_clock) begin
        if (sys_reset_n) begin
            check_value("cpu_be_o", 32'(cpu_be), 32'(slot_model >= 4'd8));
            check_value("cpu_clock_o", 32'(cpu_clock), 32'(slot_model >= 4'd12));
            check_value("cpu_addr_oe_o", 32'(cpu_addr_oe), 32'(slot_model < 4'd8));
            check_value("cpu_data_oe_o", 32'(cpu_data_oe),
                        32'(ram_we && (slot_model < 4'd8)));
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            value[i] = lfsr_state[0];
        end
        return value;
    endfunction

    // Biased toward IO, chip selects and video RAM
    function automatic logic [15:0] random_cpu_addr();
        logic [1:0] region;
        region = 2'(random_bits(2));
        case (region)
            2'd0:    return 16'(random_bits(16));
            2'd1:    return {8'hE8, 8'(random_bits(8))};
            2'd2:    return {8'hE8, 4'(4'd1 << random_bits(2)), 4'(random_bits(4))};
            default: return {4'h8, 12'(random_bits(12))};
        endcase
    endfunction

    function automatic logic in_io(input logic [15:0] a);
        return a[15:8] == 8'hE8;
    endfunction

    function automatic logic in_vram(input logic [15:0] a);
        return a[15:12] == 4'h8;
    endfunction

    function automatic logic in_rom(input logic [15:0] a);
        return ((a >= 16'h9000) && (a < 16'hE800)) || (a >= 16'hF000);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] %s: got %0h, expected %0h", name, got, expected);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("passed: %s", name);
        end else begin
            fail_count++;
            $display("failed: %s (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic next_cycle();
        @(posedge sys_clock);
        #0.5;
    endtask

    // One controller transfer, stb dropped after acceptance
    task automatic bus_access(input logic write, input logic [16:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        rdata      = 8'h00;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = write;
        wb_req.addr = addr;
        wb_req.data = wdata;
        waited = 0;
        @(negedge sys_clock);
        while (wb_rsp.stall && waited < TIMEOUT_CYCLES) begin
            @(negedge sys_clock);
            waited++;
        end
        assert (!wb_rsp.stall) else begin
            $display("request to address %h was never accepted", addr);
            test_errors++;
        end
        next_cycle();                   // Accepted on this edge
        wb_req.stb = 1'b0;
        waited = 0;
        @(negedge sys_clock);
        while (!wb_rsp.ack && waited < TIMEOUT_CYCLES) begin
            @(negedge sys_clock);
            waited++;
        end
        assert (wb_rsp.ack) else begin
            $display("no acknowledge for address %h before the timeout", addr);
            test_errors++;
        end
        rdata = wb_rsp.data;
        next_cycle();
        wb_req.cyc = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] offset, input logic [7:0] data);
        logic [7:0] unused;
        bus_access(1'b1, {1'b1, offset}, data, unused);
    endtask

    task automatic read_reg(input logic [15:0] offset, output logic [7:0] data);
        bus_access(1'b0, {1'b1, offset}, 8'h00, data);
    endtask

    // Returns just after an edge that starts a CPU-owned slot
    task automatic enter_cpu_slot();
        int waited;
        waited = 0;
        next_cycle();
        while (!cpu_be && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        assert (cpu_be) else begin
            $display("CPU bus phase never started");
            test_errors++;
        end
    endtask

    task automatic test_reset();
        check_value("cpu_ready_o", 32'(cpu_ready), 0);
        check_value("cpu_nmi_o", 32'(cpu_nmi), 0);
        check_value("cpu_reset_o", 32'(cpu_reset), 1);
        repeat (16) begin                           // One full CPU cycle
            @(negedge sys_clock);
            if (!cpu_be) begin
                check_value("ram_oe_o", 32'(ram_oe), 0);
                check_value("ram_we_o", 32'(ram_we), 0);
            end
            check_value("wb_rsp_o.ack", 32'(wb_rsp.ack), 0);
        end
        next_cycle();
        finish_test("after reset");
    endtask

    task automatic test_registers();
        logic [7:0] data;
        logic [7:0] got;
        logic [2:0] straps;
        for (int round = 0; round < 4; round++) begin
            straps          = 3'(random_bits(3));
            config_crt      = straps[0];
            config_keyboard = straps[1];
            graphic         = straps[2];
            read_reg(pet_bus_pkg::REG_STATUS, got);
            check_value("status", 32'(got), 32'(straps));

            data = 8'(random_bits(8));
            write_reg(pet_bus_pkg::REG_CPU_CTRL, data);
            check_value("cpu_ready_o", 32'(cpu_ready), 32'(data[0]));
            check_value("cpu_reset_o", 32'(cpu_reset), 32'(data[1]));
            check_value("cpu_nmi_o", 32'(cpu_nmi), 32'(data[2]));
            read_reg(pet_bus_pkg::REG_CPU_CTRL, got);
            check_value("cpu_ctrl", 32'(got), 32'(data[2:0]));

            data = 8'(random_bits(8));
            write_reg(pet_bus_pkg::REG_VIDEO_MASK, data);
            read_reg(pet_bus_pkg::REG_VIDEO_MASK, got);
            check_value("video_mask", 32'(got), 32'(data[1:0]));
        end
        read_reg(16'd3, got);           // Unmapped
        check_value("unmapped_reg", 32'(got), 0);
        finish_test("registers");
    endtask

    task automatic test_ram_traffic();
        logic [15:0] addr_list [20];
        logic [7:0]  data;
        logic [7:0]  got;
        for (int i = 0; i < 20; i++) begin
            addr_list[i] = 16'(random_bits(16));
            data         = 8'(random_bits(8));
            bus_access(1'b1, {1'b0, addr_list[i]}, data, got);
            expected_mem[addr_list[i]] = data;
        end
        for (int i = 0; i < 20; i++) begin
            bus_access(1'b0, {1'b0, addr_list[i]}, 8'h00, got);
            check_value("wb_rsp_o.data", 32'(got), 32'(expected_mem[addr_list[i]]));
        end
        finish_test("controller RAM traffic");
    endtask

    task automatic test_cpu_decode();
        for (int i = 0; i < CPU_SAMPLES; i++) begin
            enter_cpu_slot();
            cpu_addr = random_cpu_addr();
            cpu_we   = 1'b0;
            @(negedge sys_clock);
            check_value("io_oe_o", 32'(io_oe), 32'(in_io(cpu_addr)));
            check_value("pia1_cs_o", 32'(pia1_cs), 32'(cpu_addr[15:4] == 12'hE81));
            check_value("pia2_cs_o", 32'(pia2_cs), 32'(cpu_addr[15:4] == 12'hE82));
            check_value("via_cs_o", 32'(via_cs), 32'(cpu_addr[15:4] == 12'hE84));
            check_value("ram_oe_o", 32'(ram_oe), 32'(!in_io(cpu_addr)));
        end
        finish_test("CPU-phase decode");
    endtask

    task automatic test_write_protect();
        logic expected;
        for (int i = 0; i < CPU_SAMPLES; i++) begin
            enter_cpu_slot();
            cpu_addr = random_cpu_addr();
            cpu_we   = 1'b1;
            @(negedge sys_clock);
            // Writes only land during phi2
            expected = (slot_model >= 4'd12) && !in_io(cpu_addr) && !in_rom(cpu_addr);
            check_value("ram_we_o", 32'(ram_we), 32'(expected));
        end
        next_cycle();
        cpu_we = 1'b0;
        finish_test("write protection");
    endtask

    task automatic test_video_wrap();
        logic [1:0] mask;
        logic       a10_exp;
        logic       a11_exp;
        for (int round = 0; round < 3; round++) begin
            next_cycle();
            mask = 2'(random_bits(2));
            write_reg(pet_bus_pkg::REG_VIDEO_MASK, {6'd0, mask});
            for (int i = 0; i < 16; i++) begin
                enter_cpu_slot();
                cpu_addr = random_cpu_addr();
                cpu_we   = 1'b0;
                @(negedge sys_clock);
                a10_exp = cpu_addr[10] && (!in_vram(cpu_addr) || mask[0]);
                a11_exp = cpu_addr[11] && (!in_vram(cpu_addr) || mask[1]);
                check_value("ram_addr_a10_o", 32'(ram_a10), 32'(a10_exp));
                check_value("ram_addr_a11_o", 32'(ram_a11), 32'(a11_exp));
            end
        end
        finish_test("video wrap");
    endtask

    initial begin
        lfsr_state      = 32'h151c6cd8;
        test_errors     = 0;
        pass_count      = 0;
        fail_count      = 0;
        sys_reset_n     = 1'b0;
        wb_req          = '0;
        cpu_addr        = 16'h0000;
        cpu_we          = 1'b0;
        config_crt      = 1'b0;
        config_keyboard = 1'b0;
        graphic         = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            ram_mem[a]      = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
            expected_mem[a] = ram_mem[a];
        end

        repeat (5) @(posedge sys_clock);
        #0.5;
        sys_reset_n = 1'b1;

        test_reset();
        test_registers();
        test_ram_traffic();
        test_cpu_decode();
        test_write_protect();
        test_video_wrap();

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
rtl/pet_bus_pkg.sv
rtl/bus_timing.sv
rtl/wb_address_map.sv
rtl/ram_bridge.sv
rtl/control_regs.sv
rtl/bus_steering.sv
rtl/pet_bus_top.sv
tests/pet_bus_assertions.sv
tests/tb_pet_bus.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pet_bus -f all.f -o sim_pet_bus

out=$(./obj_dir/sim_pet_bus 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test OK"
